// ==== token_engine_pkg.sv ====
`default_nettype none

package token_engine_pkg;

    localparam int DATA_W   = 32;  // one GLB word
    localparam int ADDR_W   = 32;  // byte address
    localparam int WEIGHT_W = 8;
    localparam int CNT_W    = 16;  // num_weights, row_len
    localparam int SCALE_W  = 6;
    localparam int WEB_W    = 4;   // all ones on write

    // layer-1 pass states
    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_LOAD,
        INIT_FIFO,
        PREHEAT,
        NORMAL_LOOP,
        DONE
    } pass_state_e;

    // what the GLB port does this cycle
    typedef enum logic [1:0] {
        OP_IDLE,
        OP_READ,
        OP_WRITE
    } glb_op_e;

endpackage

`default_nettype wire

// ==== pass_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pass_sequencer import token_engine_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    input  logic pass_start_i,
    input  logic weight_load_done_i,
    input  logic preheat_done_i,
    input  logic normal_loop_done_i,
    output logic pass_done_o,
    output logic weight_load_state_o,
    output logic init_fifo_state_o,
    output logic preheat_state_o,
    output logic normal_loop_state_o,
    output logic ifmap_fifo_reset_o,
    output logic opsum_fifo_reset_o
);

    pass_state_e state, state_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:        if (pass_start_i) state_nxt = WEIGHT_LOAD;
            WEIGHT_LOAD: if (weight_load_done_i) state_nxt = INIT_FIFO;
            INIT_FIFO:   state_nxt = PREHEAT;  // single cycle
            PREHEAT:     if (preheat_done_i) state_nxt = NORMAL_LOOP;
            NORMAL_LOOP: if (normal_loop_done_i) state_nxt = DONE;
            DONE:        state_nxt = IDLE;
            default:     state_nxt = IDLE;
        endcase
    end

    // level outputs to the workers
    assign weight_load_state_o = (state == WEIGHT_LOAD);
    assign init_fifo_state_o   = (state == INIT_FIFO);
    assign preheat_state_o     = (state == PREHEAT);
    assign normal_loop_state_o = (state == NORMAL_LOOP);
    assign pass_done_o         = (state == DONE);

    // both FIFOs are flushed during the init cycle
    assign ifmap_fifo_reset_o = init_fifo_state_o;
    assign opsum_fifo_reset_o = init_fifo_state_o;

    a_one_state: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({weight_load_state_o, init_fifo_state_o, preheat_state_o,
                  normal_loop_state_o}));

endmodule

`default_nettype wire

// ==== weight_load_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_load_ctrl import token_engine_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 weight_load_state_i,
    input  logic [ADDR_W-1:0]    weight_base_i,     // in words
    input  logic [CNT_W-1:0]     num_weights_i,
    input  logic                 permit_i,
    input  logic [DATA_W-1:0]    glb_read_data_i,
    output logic                 req_o,
    output logic [ADDR_W-1:0]    addr_o,
    output logic [WEIGHT_W-1:0]  weight_in_o,
    output logic [NUM_LANES-1:0] weight_load_en_o,
    output logic                 weight_load_done_o
);

    logic [CNT_W-1:0] issue_cnt;
    logic [CNT_W-1:0] ret_cnt;
    logic             rd_valid;  // read data on the bus this cycle

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_cnt <= '0;
            ret_cnt   <= '0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= permit_i;
            if (!weight_load_state_i) begin
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end else begin
                if (permit_i)
                    issue_cnt <= issue_cnt + CNT_W'(1);
                if (rd_valid)
                    ret_cnt <= ret_cnt + CNT_W'(1);
            end
        end
    end

    assign req_o  = weight_load_state_i && (issue_cnt != num_weights_i);
    assign addr_o = (weight_base_i + ADDR_W'(issue_cnt)) << 2;  // word to byte

    // low byte goes to the lane picked by the weight index
    assign weight_in_o      = glb_read_data_i[WEIGHT_W-1:0];
    assign weight_load_en_o = rd_valid ? (NUM_LANES'(1) << (ret_cnt % NUM_LANES)) : '0;

    assign weight_load_done_o = rd_valid && (ret_cnt == num_weights_i - CNT_W'(1));

endmodule

`default_nettype wire

// ==== lane_fifo_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_fifo_ctrl import token_engine_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 preheat_state_i,
    input  logic                 normal_loop_state_i,
    input  logic [ADDR_W-1:0]    ifmap_base_i,
    input  logic [ADDR_W-1:0]    opsum_base_i,
    input  logic [CNT_W-1:0]     row_len_i,
    input  logic [NUM_LANES-1:0] ifmap_permit_i,
    input  logic [NUM_LANES-1:0] opsum_permit_i,
    input  logic [DATA_W-1:0]    glb_read_data_i,
    output logic [NUM_LANES-1:0] ifmap_req_o,
    output logic [NUM_LANES-1:0] opsum_req_o,
    output logic [ADDR_W-1:0]    ifmap_addr_o,
    output logic [ADDR_W-1:0]    opsum_addr_o,
    output logic [NUM_LANES-1:0] ifmap_push_o,
    output logic [DATA_W-1:0]    ifmap_push_data_o,
    output logic                 preheat_done_o,
    output logic                 normal_loop_done_o
);

    localparam int LANE_W = $clog2(NUM_LANES);

    logic [NUM_LANES-1:0] rd_pend;    // lanes still to read this phase
    logic [NUM_LANES-1:0] wr_pend;    // lanes still to write this round
    logic [CNT_W-1:0]     round;
    logic [CNT_W-1:0]     rd_row;
    logic                 pre_q, nor_q;
    logic                 rd_valid, rd_last_q;
    logic [LANE_W-1:0]    tag;        // lane of the read in flight
    logic [LANE_W-1:0]    rd_lane, wr_lane;
    logic                 rd_last, wr_last, last_round;

    // lowest pending lane, same order the arbiter uses
    always_comb begin
        rd_lane = '0;
        wr_lane = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (rd_pend[i])
                rd_lane = LANE_W'(i);
            if (wr_pend[i])
                wr_lane = LANE_W'(i);
        end
    end

    assign rd_last    = |ifmap_permit_i && ((rd_pend & ~ifmap_permit_i) == '0);
    assign wr_last    = |opsum_permit_i && ((wr_pend & ~opsum_permit_i) == '0);
    assign last_round = (round + CNT_W'(1)) == row_len_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_pend   <= '0;
            wr_pend   <= '0;
            round     <= '0;
            rd_row    <= '0;
            pre_q     <= 1'b0;
            nor_q     <= 1'b0;
            rd_valid  <= 1'b0;
            rd_last_q <= 1'b0;
        end else begin
            pre_q     <= preheat_state_i;
            nor_q     <= normal_loop_state_i;
            rd_valid  <= |ifmap_permit_i;
            rd_last_q <= rd_last;
            rd_pend   <= rd_pend & ~ifmap_permit_i;
            wr_pend   <= wr_pend & ~opsum_permit_i;
            if (preheat_state_i && !pre_q) begin  // preheat fetches row 0
                rd_pend <= '1;
                rd_row  <= '0;
            end
            if (normal_loop_state_i && !nor_q) begin
                wr_pend <= '1;
                round   <= '0;
            end
            // writes of a round done, fetch the next row
            if (normal_loop_state_i && wr_last && !last_round) begin
                rd_pend <= '1;
                rd_row  <= round + CNT_W'(1);
            end
            if (normal_loop_state_i && rd_last) begin
                wr_pend <= '1;
                round   <= round + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|ifmap_permit_i)
            tag <= rd_lane;
    end

    assign ifmap_req_o  = rd_pend;
    assign opsum_req_o  = wr_pend;
    assign ifmap_addr_o = (ifmap_base_i + ADDR_W'(rd_row) * ADDR_W'(NUM_LANES)
                           + ADDR_W'(rd_lane)) << 2;
    assign opsum_addr_o = (opsum_base_i + ADDR_W'(round) * ADDR_W'(NUM_LANES)
                           + ADDR_W'(wr_lane)) << 2;

    assign ifmap_push_o      = rd_valid ? (NUM_LANES'(1) << tag) : '0;
    assign ifmap_push_data_o = glb_read_data_i;  // word goes in unchanged

    assign preheat_done_o     = preheat_state_i && rd_valid && rd_last_q;
    assign normal_loop_done_o = normal_loop_state_i && wr_last && last_round;

    // arbiter must only answer lanes that asked
    a_permit_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((ifmap_permit_i & ~ifmap_req_o) == '0) && ((opsum_permit_i & ~opsum_req_o) == '0));

endmodule

`default_nettype wire

// ==== glb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module glb_arbiter import token_engine_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                              weight_req_i,
    input  logic [ADDR_W-1:0]                 weight_addr_i,
    input  logic [NUM_LANES-1:0]              ifmap_req_i,
    input  logic [ADDR_W-1:0]                 ifmap_addr_i,
    input  logic [NUM_LANES-1:0]              opsum_req_i,
    input  logic [ADDR_W-1:0]                 opsum_addr_i,
    input  logic [NUM_LANES-1:0][DATA_W-1:0]  opsum_pop_data_i,
    output logic                              weight_permit_o,
    output logic [NUM_LANES-1:0]              ifmap_permit_o,
    output logic [NUM_LANES-1:0]              opsum_permit_o,
    output logic                              glb_en_o,
    output logic [WEB_W-1:0]                  glb_web_o,
    output logic [ADDR_W-1:0]                 glb_addr_o,
    output logic [DATA_W-1:0]                 raw_write_data_o,
    output logic [NUM_LANES-1:0]              opsum_pop_o
);

    glb_op_e op;

    // weight first, then opsum writes, then ifmap reads
    always_comb begin
        op              = OP_IDLE;
        weight_permit_o = 1'b0;
        ifmap_permit_o  = '0;
        opsum_permit_o  = '0;
        glb_addr_o      = '0;
        if (weight_req_i) begin
            op              = OP_READ;
            weight_permit_o = 1'b1;
            glb_addr_o      = weight_addr_i;
        end else if (|opsum_req_i) begin
            op             = OP_WRITE;
            opsum_permit_o = opsum_req_i & (~opsum_req_i + NUM_LANES'(1));  // lowest lane
            glb_addr_o     = opsum_addr_i;
        end else if (|ifmap_req_i) begin
            op             = OP_READ;
            ifmap_permit_o = ifmap_req_i & (~ifmap_req_i + NUM_LANES'(1));
            glb_addr_o     = ifmap_addr_i;
        end
    end

    always_comb begin
        raw_write_data_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (opsum_permit_o[i])
                raw_write_data_o = opsum_pop_data_i[i];
        end
    end

    assign glb_en_o    = (op != OP_IDLE);
    assign glb_web_o   = (op == OP_WRITE) ? '1 : '0;
    assign opsum_pop_o = opsum_permit_o;  // FWFT word leaves with the write

    always_comb begin
        a_one_permit: assert ($onehot0({weight_permit_o, ifmap_permit_o, opsum_permit_o}))
            else $error("more than one GLB permit");
    end

endmodule

`default_nettype wire

// ==== ppu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu import token_engine_pkg::*; (
    input  logic [DATA_W-1:0]  data_i,
    input  logic [SCALE_W-1:0] scaling_factor_i,
    input  logic               relu_en_i,
    input  logic               need_ppu_i,
    output logic [DATA_W-1:0]  data_o
);

    logic signed [DATA_W-1:0] shifted;

    assign shifted = $signed(data_i) >>> scaling_factor_i;  // keeps the sign

    always_comb begin
        if (!need_ppu_i)
            data_o = data_i;  // bypass
        else if (relu_en_i && shifted[DATA_W-1])
            data_o = '0;
        else
            data_o = shifted;
    end

endmodule

`default_nettype wire

// ==== token_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module token_engine import token_engine_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             pass_start_i,
    output logic                             pass_done_o,
    input  logic [ADDR_W-1:0]                weight_base_i,  // word addresses
    input  logic [ADDR_W-1:0]                ifmap_base_i,
    input  logic [ADDR_W-1:0]                opsum_base_i,
    input  logic [CNT_W-1:0]                 num_weights_i,
    input  logic [CNT_W-1:0]                 row_len_i,
    input  logic [SCALE_W-1:0]               scaling_factor_i,
    input  logic                             relu_en_i,
    input  logic                             need_ppu_i,
    input  logic [DATA_W-1:0]                glb_read_data_i,
    output logic                             glb_en_o,
    output logic [WEB_W-1:0]                 glb_web_o,
    output logic [ADDR_W-1:0]                glb_addr_o,
    output logic [DATA_W-1:0]                glb_write_data_o,
    output logic [WEIGHT_W-1:0]              weight_in_o,
    output logic [NUM_LANES-1:0]             weight_load_en_o,
    output logic                             ifmap_fifo_reset_o,
    output logic                             opsum_fifo_reset_o,
    output logic [NUM_LANES-1:0]             ifmap_push_o,
    output logic [DATA_W-1:0]                ifmap_push_data_o,
    output logic [NUM_LANES-1:0]             opsum_pop_o,
    input  logic [NUM_LANES-1:0][DATA_W-1:0] opsum_pop_data_i
);

    logic weight_load_state, preheat_state, normal_loop_state;
    logic weight_load_done, preheat_done, normal_loop_done;

    logic                 weight_req, weight_permit;
    logic [ADDR_W-1:0]    weight_addr, ifmap_addr, opsum_addr;
    logic [NUM_LANES-1:0] ifmap_req, ifmap_permit, opsum_req, opsum_permit;
    logic [DATA_W-1:0]    raw_write_data;

    pass_sequencer u_pass_sequencer (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .pass_start_i       (pass_start_i),
        .weight_load_done_i (weight_load_done),
        .preheat_done_i     (preheat_done),
        .normal_loop_done_i (normal_loop_done),
        .pass_done_o        (pass_done_o),
        .weight_load_state_o(weight_load_state),
        .init_fifo_state_o  (),
        .preheat_state_o    (preheat_state),
        .normal_loop_state_o(normal_loop_state),
        .ifmap_fifo_reset_o (ifmap_fifo_reset_o),
        .opsum_fifo_reset_o (opsum_fifo_reset_o)
    );

    weight_load_ctrl #(.NUM_LANES(NUM_LANES)) u_weight_load_ctrl (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .weight_load_state_i(weight_load_state),
        .weight_base_i      (weight_base_i),
        .num_weights_i      (num_weights_i),
        .permit_i           (weight_permit),
        .glb_read_data_i    (glb_read_data_i),
        .req_o              (weight_req),
        .addr_o             (weight_addr),
        .weight_in_o        (weight_in_o),
        .weight_load_en_o   (weight_load_en_o),
        .weight_load_done_o (weight_load_done)
    );

    lane_fifo_ctrl #(.NUM_LANES(NUM_LANES)) u_lane_fifo_ctrl (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .preheat_state_i    (preheat_state),
        .normal_loop_state_i(normal_loop_state),
        .ifmap_base_i       (ifmap_base_i),
        .opsum_base_i       (opsum_base_i),
        .row_len_i          (row_len_i),
        .ifmap_permit_i     (ifmap_permit),
        .opsum_permit_i     (opsum_permit),
        .glb_read_data_i    (glb_read_data_i),
        .ifmap_req_o        (ifmap_req),
        .opsum_req_o        (opsum_req),
        .ifmap_addr_o       (ifmap_addr),
        .opsum_addr_o       (opsum_addr),
        .ifmap_push_o       (ifmap_push_o),
        .ifmap_push_data_o  (ifmap_push_data_o),
        .preheat_done_o     (preheat_done),
        .normal_loop_done_o (normal_loop_done)
    );

    glb_arbiter #(.NUM_LANES(NUM_LANES)) u_glb_arbiter (
        .weight_req_i    (weight_req),
        .weight_addr_i   (weight_addr),
        .ifmap_req_i     (ifmap_req),
        .ifmap_addr_i    (ifmap_addr),
        .opsum_req_i     (opsum_req),
        .opsum_addr_i    (opsum_addr),
        .opsum_pop_data_i(opsum_pop_data_i),
        .weight_permit_o (weight_permit),
        .ifmap_permit_o  (ifmap_permit),
        .opsum_permit_o  (opsum_permit),
        .glb_en_o        (glb_en_o),
        .glb_web_o       (glb_web_o),
        .glb_addr_o      (glb_addr_o),
        .raw_write_data_o(raw_write_data),
        .opsum_pop_o     (opsum_pop_o)
    );

    // results are scaled on their way into the GLB
    ppu u_ppu (
        .data_i          (raw_write_data),
        .scaling_factor_i(scaling_factor_i),
        .relu_en_i       (relu_en_i),
        .need_ppu_i      (need_ppu_i),
        .data_o          (glb_write_data_o)
    );

endmodule

`default_nettype wire

// ==== tb_token_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_token_engine import token_engine_pkg::*; ();

    localparam int NUM_LANES = 4;
    localparam int MAX_TXN   = 64;
    localparam int MAX_ROWS  = 8;

    logic                             clk;
    logic                             rst_n_i;
    logic                             pass_start_i;
    logic                             pass_done_o;
    logic [ADDR_W-1:0]                weight_base_i, ifmap_base_i, opsum_base_i;
    logic [CNT_W-1:0]                 num_weights_i, row_len_i;
    logic [SCALE_W-1:0]               scaling_factor_i;
    logic                             relu_en_i, need_ppu_i;
    logic [DATA_W-1:0]                glb_read_data_i;
    logic                             glb_en_o;
    logic [WEB_W-1:0]                 glb_web_o;
    logic [ADDR_W-1:0]                glb_addr_o;
    logic [DATA_W-1:0]                glb_write_data_o;
    logic [WEIGHT_W-1:0]              weight_in_o;
    logic [NUM_LANES-1:0]             weight_load_en_o;
    logic                             ifmap_fifo_reset_o, opsum_fifo_reset_o;
    logic [NUM_LANES-1:0]             ifmap_push_o;
    logic [DATA_W-1:0]                ifmap_push_data_o;
    logic [NUM_LANES-1:0]             opsum_pop_o;
    logic [NUM_LANES-1:0][DATA_W-1:0] opsum_pop_data_i;

    // GLB model and opsum FIFO models
    logic [DATA_W-1:0] glb_mem [0:511];
    logic [DATA_W-1:0] opsum_val [NUM_LANES][MAX_ROWS];
    int                pop_ptr [NUM_LANES];

    // expected transaction list
    int                n_txn;
    int                txn_pass [MAX_TXN];
    glb_op_e           txn_op [MAX_TXN];
    logic [ADDR_W-1:0] txn_addr [MAX_TXN];
    logic [DATA_W-1:0] txn_data [MAX_TXN];
    logic              cfg_need_ppu;
    bit                stim_loaded;

    // monitor state
    int                   txn_idx, pass_no, rd_cnt, ifmap_rd_cnt, done_cnt, rst_cnt;
    int                   rd_kind;          // 0 none, 1 weight, 2 ifmap
    int                   rd_lane;
    logic [DATA_W-1:0]    rd_exp;
    logic                 rd_issue, fifo_clear;
    logic [DATA_W-1:0]    rd_next;
    logic [NUM_LANES-1:0] pop_next;

    token_engine #(.NUM_LANES(NUM_LANES)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_txn(input glb_op_e exp_op, input logic [ADDR_W-1:0] exp_addr,
                             input logic [DATA_W-1:0] exp_data, input glb_op_e act_op,
                             input logic [ADDR_W-1:0] act_addr,
                             input logic [DATA_W-1:0] act_data);
        if (exp_op != act_op) begin
            $display("Fail glb op (web %h) expected %h got %h", glb_web_o, exp_op, act_op);
            fail_now("GLB operation mismatch");
        end
        if (exp_addr != act_addr) begin
            $display("Fail glb_addr_o expected %h got %h", exp_addr, act_addr);
            fail_now("GLB address mismatch");
        end
        if (exp_op == OP_WRITE && exp_data !== act_data) begin
            $display("Fail glb_write_data_o expected %h got %h", exp_data, act_data);
            fail_now("GLB write data mismatch");
        end
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (exp !== act) begin
            $display("Fail %s expected %h got %h", name, exp, act);
            fail_now("data word mismatch");
        end
    endtask

    task automatic check_weight(input logic [WEIGHT_W-1:0] exp, input logic [WEIGHT_W-1:0] act);
        if (exp !== act) begin
            $display("Fail weight_in_o expected %h got %h", exp, act);
            fail_now("weight byte mismatch");
        end
    endtask

    task automatic check_lanes(input string name, input logic [NUM_LANES-1:0] exp,
                               input logic [NUM_LANES-1:0] act);
        if (exp !== act) begin
            $display("Fail %s expected %h got %h", name, exp, act);
            fail_now("lane strobe mismatch");
        end
    endtask

    function automatic logic [NUM_LANES-1:0] lane_bit(input int lane);
        return NUM_LANES'(1) << lane;
    endfunction

    task automatic load_stim();
        int fd, r, cnt, a, lane, row, p, op;
        logic [DATA_W-1:0] d;
        logic [ADDR_W-1:0] ad;
        string line;
        for (int i = 0; i < 512; i++)
            glb_mem[i] = 32'hA500_0000 | i;  // fill tied to the word address
        fd = $fopen("token_engine_stim.txt", "r");
        if (fd == 0)
            fail_now("cannot open token_engine_stim.txt");
        r = $fgets(line, fd);  // two column header lines
        r = $fgets(line, fd);
        r = $fscanf(fd, "%h %h %h %h %h %h %h %h", weight_base_i, ifmap_base_i,
                    opsum_base_i, num_weights_i, row_len_i, scaling_factor_i,
                    relu_en_i, cfg_need_ppu);
        if (r != 8)
            fail_now("configuration line in stim file is incomplete");
        r = $fscanf(fd, "%d", cnt);
        for (int i = 0; i < cnt; i++) begin
            r = $fscanf(fd, "%h %h", a, d);
            if (r != 2)
                fail_now("GLB memory section in stim file is short");
            glb_mem[a] = d;
        end
        r = $fscanf(fd, "%d", cnt);
        for (int i = 0; i < cnt; i++) begin
            r = $fscanf(fd, "%d %d %h", lane, row, d);
            if (r != 3)
                fail_now("opsum section in stim file is short");
            opsum_val[lane][row] = d;
        end
        r = $fscanf(fd, "%d", n_txn);
        for (int i = 0; i < n_txn; i++) begin
            r = $fscanf(fd, "%d %d %h %h", p, op, ad, d);
            if (r != 4)
                fail_now("transaction list in stim file is short");
            txn_pass[i] = p;
            txn_op[i]   = glb_op_e'(op);
            txn_addr[i] = ad;
            txn_data[i] = d;
        end
        $fclose(fd);
        stim_loaded = 1'b1;
    endtask

    // one cycle of checks, sampled mid-cycle
    task automatic check_cycle();
        glb_op_e           act_op;
        logic [ADDR_W-1:0] word;
        if (rd_kind == 1) begin
            check_weight(rd_exp[WEIGHT_W-1:0], weight_in_o);
            check_lanes("weight_load_en_o", lane_bit(rd_lane), weight_load_en_o);
        end else begin
            check_lanes("weight_load_en_o", '0, weight_load_en_o);
        end
        if (rd_kind == 2) begin
            check_lanes("ifmap_push_o", lane_bit(rd_lane), ifmap_push_o);
            check_word("ifmap_push_data_o", rd_exp, ifmap_push_data_o);
        end else begin
            check_lanes("ifmap_push_o", '0, ifmap_push_o);
        end
        rd_kind = 0;
        if (ifmap_fifo_reset_o || opsum_fifo_reset_o) begin
            if (!(ifmap_fifo_reset_o && opsum_fifo_reset_o))
                fail_now("ifmap and opsum FIFO resets did not pulse together");
            if (ifmap_rd_cnt != 0)
                fail_now("FIFO reset came after an ifmap read");
            rst_cnt++;
            fifo_clear = 1'b1;
        end
        if (pass_done_o)
            done_cnt++;
        if (!glb_en_o) begin
            if (glb_web_o !== '0) begin
                $display("Fail glb_web_o expected %h got %h", WEB_W'(0), glb_web_o);
                fail_now("write enable set without a GLB access");
            end
            check_lanes("opsum_pop_o", '0, opsum_pop_o);
            return;
        end
        if (txn_idx >= n_txn)
            fail_now("GLB access beyond the end of the expected list");
        if (txn_pass[txn_idx] != pass_no)
            fail_now("GLB access outside the pass it belongs to");
        if (glb_web_o == '1)
            act_op = OP_WRITE;
        else if (glb_web_o == '0)
            act_op = OP_READ;
        else
            act_op = OP_IDLE;
        check_txn(txn_op[txn_idx], txn_addr[txn_idx], txn_data[txn_idx],
                  act_op, glb_addr_o, glb_write_data_o);
        word = glb_addr_o >> 2;
        if (act_op == OP_READ) begin
            check_lanes("opsum_pop_o", '0, opsum_pop_o);
            rd_issue = 1'b1;
            rd_next  = glb_mem[word[8:0]];
            rd_exp   = txn_data[txn_idx];
            if (rd_cnt < int'(num_weights_i)) begin
                rd_kind = 1;
                rd_lane = rd_cnt % NUM_LANES;
            end else begin
                rd_kind = 2;
                rd_lane = int'(word - ifmap_base_i) % NUM_LANES;
                ifmap_rd_cnt++;
            end
            rd_cnt++;
        end else begin
            check_lanes("opsum_pop_o", lane_bit(int'(word - opsum_base_i) % NUM_LANES),
                        opsum_pop_o);
            glb_mem[word[8:0]] = glb_write_data_o;
            pop_next = opsum_pop_o;
        end
        txn_idx++;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n_i)
                check_cycle();
        end
    end

    // GLB read return and FIFO pointers move just after the edge
    always @(posedge clk) begin
        #1;
        glb_read_data_i = rd_issue ? rd_next : '0;
        rd_issue = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (fifo_clear)
                pop_ptr[i] = 0;
            else if (pop_next[i])
                pop_ptr[i] = pop_ptr[i] + 1;
        end
        fifo_clear = 1'b0;
        pop_next   = '0;
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++)
            opsum_pop_data_i[i] = opsum_val[i][pop_ptr[i] % MAX_ROWS];  // FWFT head
    end

    task automatic run_pass(input int p, input logic need);
        int exp_end;
        exp_end = 0;
        for (int i = 0; i < n_txn; i++)
            if (txn_pass[i] <= p)
                exp_end++;
        pass_no      = p;
        rd_cnt       = 0;
        ifmap_rd_cnt = 0;
        need_ppu_i   = need;
        pass_start_i = 1'b1;
        @(posedge clk);
        #1 pass_start_i = 1'b0;
        wait (done_cnt == p);
        @(posedge clk);
        #1;
        if (txn_idx != exp_end) begin
            $display("pass %0d ended after %0d GLB accesses, %0d expected", p, txn_idx, exp_end);
            fail_now("pass ended with a wrong number of GLB accesses");
        end
    endtask

    initial begin
        int limit;
        wait (stim_loaded);
        limit = (n_txn + 50) * 4;
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        fail_now("timeout");
    end

    initial begin
        rst_n_i          = 1'b0;
        pass_start_i     = 1'b0;
        weight_base_i    = '0;
        ifmap_base_i     = '0;
        opsum_base_i     = '0;
        num_weights_i    = '0;
        row_len_i        = '0;
        scaling_factor_i = '0;
        relu_en_i        = 1'b0;
        need_ppu_i       = 1'b0;
        glb_read_data_i  = '0;
        rd_issue         = 1'b0;
        fifo_clear       = 1'b0;
        pop_next         = '0;
        rd_kind          = 0;
        txn_idx          = 0;
        pass_no          = 0;
        done_cnt         = 0;
        rst_cnt          = 0;
        for (int i = 0; i < NUM_LANES; i++)
            pop_ptr[i] = 0;
        load_stim();
        repeat (3) @(posedge clk);
        #1 rst_n_i = 1'b1;
        repeat (3) @(posedge clk);  // idle cycles watched by the monitor
        #1;
        run_pass(1, cfg_need_ppu);
        repeat (2) @(posedge clk);
        #1;
        run_pass(2, 1'b0);          // bypass writes raw opsum words
        repeat (4) @(posedge clk);
        if (done_cnt != 2 || rst_cnt != 2) begin
            fail_now("pass done or FIFO reset pulsed a wrong number of times");
        end else if (txn_idx != n_txn) begin
            fail_now("not every expected GLB access happened");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== token_engine_stim.txt ====
# cfg (hex): weight_base ifmap_base opsum_base num_weights row_len scale relu need_ppu
# then: count + word_addr data | count + lane round opsum | count + pass op(1 rd,2 wr) addr data
10 20 40 3 2 2 1 1
11
10 11223344
11 cafe00a7
12 0000015c
20 01020304
21 deadbeef
22 7fff0001
23 80000010
24 00001234
25 fffffff0
26 0badf00d
27 55aa55aa
8
0 0 00000100
1 0 ffffff00
2 0 00001003
3 0 80000000
0 1 7fffffff
1 1 fffffffd
2 1 00000040
3 1 12345678
38
1 1 00000040 11223344
1 1 00000044 cafe00a7
1 1 00000048 0000015c
1 1 00000080 01020304
1 1 00000084 deadbeef
1 1 00000088 7fff0001
1 1 0000008c 80000010
1 2 00000100 00000040
1 2 00000104 00000000
1 2 00000108 00000400
1 2 0000010c 00000000
1 1 00000090 00001234
1 1 00000094 fffffff0
1 1 00000098 0badf00d
1 1 0000009c 55aa55aa
1 2 00000110 1fffffff
1 2 00000114 00000000
1 2 00000118 00000010
1 2 0000011c 048d159e
2 1 00000040 11223344
2 1 00000044 cafe00a7
2 1 00000048 0000015c
2 1 00000080 01020304
2 1 00000084 deadbeef
2 1 00000088 7fff0001
2 1 0000008c 80000010
2 2 00000100 00000100
2 2 00000104 ffffff00
2 2 00000108 00001003
2 2 0000010c 80000000
2 1 00000090 00001234
2 1 00000094 fffffff0
2 1 00000098 0badf00d
2 1 0000009c 55aa55aa
2 2 00000110 7fffffff
2 2 00000114 fffffffd
2 2 00000118 00000040
2 2 0000011c 12345678

// ==== files.f ====
token_engine_pkg.sv
pass_sequencer.sv
weight_load_ctrl.sv
lane_fifo_ctrl.sv
glb_arbiter.sv
ppu.sv
token_engine.sv
tb_token_engine.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_token_engine
FILELIST := files.f
OBJ      := obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)
	out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ)
